// File: iq_squelch_pkg.sv
// iq squelch shared package: widths, channel count, register map and reset values
`default_nettype none

package iq_squelch_pkg;

  // sample and magnitude widths
  localparam int SAMPLE_W = 12;
  localparam int MAG_W    = 16;
  localparam int HANG_W   = 8;
  localparam int NUM_CH   = 4;

  // largest magnitude the approximation can produce, |-2048| + 2048/2
  localparam int MAG_MAX = (2 ** (SAMPLE_W - 1)) * 3 / 2;

  // one I/Q pair, I in the upper half
  typedef logic [2*SAMPLE_W-1:0] iq_sample_t;

  // apb byte addresses
  localparam logic [3:0] ADDR_THRESH = 4'h0;
  localparam logic [3:0] ADDR_HANG   = 4'h4;
  localparam logic [3:0] ADDR_ENABLE = 4'h8;
  localparam logic [3:0] ADDR_STATUS = 4'hC;

  // settings after reset
  localparam logic [MAG_W-1:0]  RST_THRESH = 16;
  localparam logic [HANG_W-1:0] RST_HANG   = 7;
  localparam logic [NUM_CH-1:0] RST_ENABLE = '1;

endpackage

`default_nettype wire

// File: iq_magnitude.sv
// complex magnitude estimate of one IQ sample, larger plus half the smaller
`timescale 1ns/1ps
`default_nettype none

module iq_magnitude
  import iq_squelch_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic signed [SAMPLE_W-1:0] i_in,
  input  wire logic signed [SAMPLE_W-1:0] q_in,
  output logic             [MAG_W-1:0]    mag
);

  logic [SAMPLE_W-1:0] abs_i_c;
  logic [SAMPLE_W-1:0] abs_q_c;
  logic [SAMPLE_W-1:0] abs_i;
  logic [SAMPLE_W-1:0] abs_q;
  logic [SAMPLE_W-1:0] larger;
  logic [SAMPLE_W-1:0] smaller;

  // -2048 maps to 2048, still fits unsigned
  assign abs_i_c = i_in[SAMPLE_W-1] ? SAMPLE_W'(-i_in) : SAMPLE_W'(i_in);
  assign abs_q_c = q_in[SAMPLE_W-1] ? SAMPLE_W'(-q_in) : SAMPLE_W'(q_in);

  assign larger  = (abs_i >= abs_q) ? abs_i : abs_q;
  assign smaller = (abs_i >= abs_q) ? abs_q : abs_i;

  // stage 1, absolute values
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      abs_i <= '0;
      abs_q <= '0;
    end else begin
      abs_i <= abs_i_c;
      abs_q <= abs_q_c;
    end
  end

  // stage 2, max + min/2
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mag <= '0;
    end else begin
      mag <= MAG_W'(larger) + MAG_W'(smaller >> 1);
    end
  end

endmodule

`default_nettype wire

// File: boxcar_avg.sv
// boxcar moving average of the magnitude over a power-of-two window
`timescale 1ns/1ps
`default_nettype none

module boxcar_avg
  import iq_squelch_pkg::*;
#(
  parameter int AVG_POWER = 4
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic [MAG_W-1:0] din,
  output logic      [MAG_W-1:0] avg
);

  localparam int WINDOW = 2 ** AVG_POWER;
  localparam int SUM_W  = MAG_W + AVG_POWER;
  localparam logic [SUM_W-1:0] SUM_MAX = SUM_W'(WINDOW * MAG_MAX);

  logic [MAG_W-1:0] window [WINDOW];
  logic [SUM_W-1:0] sum;

  //////////////////////////////////////////////////
  // window history and running sum
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < WINDOW; k++) begin
        window[k] <= '0;
      end
      sum <= '0;
    end else begin
      window[0] <= din;
      for (int k = 1; k < WINDOW; k++) begin
        window[k] <= window[k-1];
      end
      // add newest, drop the one leaving the window
      sum <= sum + SUM_W'(din) - SUM_W'(window[WINDOW-1]);
    end
  end

  // integer mean of the registered sum
  assign avg = sum[SUM_W-1:AVG_POWER];

  // the magnitude stage bounds every input, so the sum is bounded too
  a_sum_bounded : assert property (
    @(posedge clk) disable iff (!rst_n) sum <= SUM_MAX
  ) else $error("boxcar sum out of range");

endmodule

`default_nettype wire

// File: sample_delay.sv
// fixed-depth delay line for any packed payload
`timescale 1ns/1ps
`default_nettype none

module sample_delay #(
  parameter int  DEPTH = 24,
  parameter type T     = logic
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire T     din,
  output T          dout
);

  T stages [DEPTH];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < DEPTH; k++) begin
        stages[k] <= '0;
      end
    end else begin
      stages[0] <= din;
      for (int k = 1; k < DEPTH; k++) begin
        stages[k] <= stages[k-1];
      end
    end
  end

  // oldest stage
  assign dout = stages[DEPTH-1];

endmodule

`default_nettype wire

// File: squelch_gate.sv
// squelch gate for one channel with threshold compare, hang counter and valid gating
`timescale 1ns/1ps
`default_nettype none

module squelch_gate
  import iq_squelch_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic        [MAG_W-1:0]    avg,
  input  wire logic        [MAG_W-1:0]    threshold,
  input  wire logic        [HANG_W-1:0]   hang_len,
  input  wire logic                       enable,
  input  wire logic                       valid_dly,
  input  wire logic signed [SAMPLE_W-1:0] i_dly,
  input  wire logic signed [SAMPLE_W-1:0] q_dly,
  output logic                            valid_out,
  output logic signed      [SAMPLE_W-1:0] i_out,
  output logic signed      [SAMPLE_W-1:0] q_out,
  output logic                            gate_open
);

  logic              pass;
  logic [HANG_W-1:0] hang_cnt;

  assign pass      = avg > threshold;
  assign gate_open = pass || (hang_cnt < hang_len);

  // hang counter starts saturated so the gate is closed out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hang_cnt <= '1;
    end else if (pass) begin
      hang_cnt <= '0;
    end else if (hang_cnt < hang_len) begin
      hang_cnt <= hang_cnt + 1'b1;
    end
  end

  // only valid is gated and data always flows
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid_dly && gate_open && enable;
    end
  end

  always_ff @(posedge clk) begin
    i_out <= i_dly;
    q_out <= q_dly;
  end

  // a cleared counter holds the gate open in the cycle after pass
  a_hang_clear : assert property (
    @(posedge clk) disable iff (!rst_n) pass ##1 (hang_len != '0) |-> gate_open
  ) else $error("gate not held open in the cycle after pass");

endmodule

`default_nettype wire

// File: squelch_channel.sv
// one squelch channel: magnitude, boxcar average, sample delay and gate
`timescale 1ns/1ps
`default_nettype none

module squelch_channel
  import iq_squelch_pkg::*;
#(
  parameter int DELAY     = 24,
  parameter int AVG_POWER = 4
) (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       valid_in,
  input  wire logic signed [SAMPLE_W-1:0] i_in,
  input  wire logic signed [SAMPLE_W-1:0] q_in,
  output logic                            valid_out,
  output logic signed      [SAMPLE_W-1:0] i_out,
  output logic signed      [SAMPLE_W-1:0] q_out,
  input  wire logic        [MAG_W-1:0]    threshold,
  input  wire logic        [HANG_W-1:0]   hang_len,
  input  wire logic                       enable,
  output logic                            gate_open
);

  logic [MAG_W-1:0] mag;
  logic [MAG_W-1:0] avg;
  iq_sample_t       iq_dly;
  logic             valid_dly;

  //////////////////////////////////////////////////
  // level detect
  //////////////////////////////////////////////////

  iq_magnitude i_mag (
    .clk   (clk),
    .rst_n (rst_n),
    .i_in  (i_in),
    .q_in  (q_in),
    .mag   (mag)
  );

  boxcar_avg #(.AVG_POWER(AVG_POWER)) i_avg (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (mag),
    .avg   (avg)
  );

  //////////////////////////////////////////////////
  // look-ahead delay of samples and valid
  //////////////////////////////////////////////////

  sample_delay #(.DEPTH(DELAY), .T(iq_sample_t)) i_iq_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .din   ({i_in, q_in}),
    .dout  (iq_dly)
  );

  sample_delay #(.DEPTH(DELAY), .T(logic)) i_valid_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (valid_in),
    .dout  (valid_dly)
  );

  squelch_gate i_gate (
    .clk       (clk),
    .rst_n     (rst_n),
    .avg       (avg),
    .threshold (threshold),
    .hang_len  (hang_len),
    .enable    (enable),
    .valid_dly (valid_dly),
    .i_dly     (iq_dly[2*SAMPLE_W-1:SAMPLE_W]),
    .q_dly     (iq_dly[SAMPLE_W-1:0]),
    .valid_out (valid_out),
    .i_out     (i_out),
    .q_out     (q_out),
    .gate_open (gate_open)
  );

endmodule

`default_nettype wire

// File: squelch_apb_regs.sv
// APB register block holding the squelch settings and the gate status
`timescale 1ns/1ps
`default_nettype none

module squelch_apb_regs
  import iq_squelch_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              psel,
  input  wire logic              penable,
  input  wire logic              pwrite,
  input  wire logic [3:0]        paddr,
  input  wire logic [31:0]       pwdata,
  output logic      [31:0]       prdata,
  output logic                   pready,
  output logic                   pslverr,
  input  wire logic [NUM_CH-1:0] gate_open,
  output logic      [MAG_W-1:0]  threshold,
  output logic      [HANG_W-1:0] hang_len,
  output logic      [NUM_CH-1:0] ch_enable
);

  logic access;
  logic mapped;
  logic wr_ok;

  // no wait states
  assign pready = 1'b1;

  assign access = psel && penable;
  assign mapped = (paddr == ADDR_THRESH) || (paddr == ADDR_HANG) ||
                  (paddr == ADDR_ENABLE) || (paddr == ADDR_STATUS);

  // status is read only
  assign pslverr = access && (!mapped || (pwrite && paddr == ADDR_STATUS));
  assign wr_ok   = access && pwrite && !pslverr;

  //////////////////////////////////////////////////
  // settings
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      threshold <= RST_THRESH;
      hang_len  <= RST_HANG;
      ch_enable <= RST_ENABLE;
    end else if (wr_ok) begin
      case (paddr)
        ADDR_THRESH: threshold <= pwdata[MAG_W-1:0];
        ADDR_HANG:   hang_len  <= pwdata[HANG_W-1:0];
        ADDR_ENABLE: ch_enable <= pwdata[NUM_CH-1:0];
        default: ;
      endcase
    end
  end

  // read mux, valid during the access cycle
  always_comb begin
    prdata = '0;
    case (paddr)
      ADDR_THRESH: prdata[MAG_W-1:0]  = threshold;
      ADDR_HANG:   prdata[HANG_W-1:0] = hang_len;
      ADDR_ENABLE: prdata[NUM_CH-1:0] = ch_enable;
      ADDR_STATUS: prdata[NUM_CH-1:0] = gate_open;
      default: ;
    endcase
  end

  a_penable_psel : assert property (
    @(posedge clk) disable iff (!rst_n) penable |-> psel
  ) else $error("penable without psel");

endmodule

`default_nettype wire

// File: iq_squelch_top.sv
// four-channel IQ squelch gate with APB control
`timescale 1ns/1ps
`default_nettype none

module iq_squelch_top
  import iq_squelch_pkg::*;
#(
  parameter int DELAY     = 24,
  parameter int AVG_POWER = 4
) (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  // samples in, channel 0 in the lowest slice
  input  wire logic [NUM_CH-1:0]          valid_in,
  input  wire logic [NUM_CH*SAMPLE_W-1:0] i_in,
  input  wire logic [NUM_CH*SAMPLE_W-1:0] q_in,
  // samples out
  output logic      [NUM_CH-1:0]          valid_out,
  output logic      [NUM_CH*SAMPLE_W-1:0] i_out,
  output logic      [NUM_CH*SAMPLE_W-1:0] q_out,
  // apb slave
  input  wire logic                       psel,
  input  wire logic                       penable,
  input  wire logic                       pwrite,
  input  wire logic [3:0]                 paddr,
  input  wire logic [31:0]                pwdata,
  output logic      [31:0]                prdata,
  output logic                            pready,
  output logic                            pslverr
);

  logic [MAG_W-1:0]  threshold;
  logic [HANG_W-1:0] hang_len;
  logic [NUM_CH-1:0] ch_enable;
  logic [NUM_CH-1:0] gate_open;

  squelch_apb_regs i_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .gate_open (gate_open),
    .threshold (threshold),
    .hang_len  (hang_len),
    .ch_enable (ch_enable)
  );

  // one pipeline per channel
  for (genvar n = 0; n < NUM_CH; n++) begin : g_ch
    squelch_channel #(
      .DELAY     (DELAY),
      .AVG_POWER (AVG_POWER)
    ) i_ch (
      .clk       (clk),
      .rst_n     (rst_n),
      .valid_in  (valid_in[n]),
      .i_in      (i_in[n*SAMPLE_W +: SAMPLE_W]),
      .q_in      (q_in[n*SAMPLE_W +: SAMPLE_W]),
      .valid_out (valid_out[n]),
      .i_out     (i_out[n*SAMPLE_W +: SAMPLE_W]),
      .q_out     (q_out[n*SAMPLE_W +: SAMPLE_W]),
      .threshold (threshold),
      .hang_len  (hang_len),
      .enable    (ch_enable[n]),
      .gate_open (gate_open[n])
    );
  end

endmodule

`default_nettype wire

// File: tb_iq_squelch.sv
// testbench for the four-channel IQ squelch gate with random samples against a cycle model
`timescale 1ns/1ps
`default_nettype none

module tb_iq_squelch
  import iq_squelch_pkg::*;
();

  localparam int DELAY        = 24;
  localparam int AVG_POWER    = 4;
  localparam int WINDOW       = 2 ** AVG_POWER;
  localparam int LOW_CYCLES   = 300;
  localparam int HIGH_CYCLES  = 400;
  localparam int BURST_CYCLES = 100;
  localparam int QUIET_CYCLES = 150;
  localparam int ENA_CYCLES   = 300;
  // about 40 register accesses of three cycles each
  localparam int APB_CYCLES   = 40 * 3;
  localparam int TOTAL_CYCLES = 10 + 50 + LOW_CYCLES + HIGH_CYCLES + ENA_CYCLES +
                                3 * (BURST_CYCLES + QUIET_CYCLES) + APB_CYCLES;
  localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 500) * 10;

  logic                       clk      = 1'b0;
  logic                       rst_n    = 1'b0;
  logic [NUM_CH-1:0]          valid_in = '0;
  logic [NUM_CH*SAMPLE_W-1:0] i_in     = '0;
  logic [NUM_CH*SAMPLE_W-1:0] q_in     = '0;
  logic [NUM_CH-1:0]          valid_out;
  logic [NUM_CH*SAMPLE_W-1:0] i_out;
  logic [NUM_CH*SAMPLE_W-1:0] q_out;
  logic                       psel     = 1'b0;
  logic                       penable  = 1'b0;
  logic                       pwrite   = 1'b0;
  logic [3:0]                 paddr    = '0;
  logic [31:0]                pwdata   = '0;
  logic [31:0]                prdata;
  logic                       pready;
  logic                       pslverr;

  // model state with one entry per channel
  logic [MAG_W-1:0]    m_thresh;
  logic [HANG_W-1:0]   m_hang;
  logic [NUM_CH-1:0]   m_en;
  int                  m_cnt [NUM_CH];
  int                  mag_s1 [NUM_CH];
  int                  mag_s2 [NUM_CH];
  int                  hist [NUM_CH][WINDOW];
  logic [2*SAMPLE_W:0] dq [NUM_CH][DELAY];
  logic                mv [NUM_CH];
  logic [SAMPLE_W-1:0] mi [NUM_CH];
  logic [SAMPLE_W-1:0] mq [NUM_CH];

  integer seed      = 32'hf580;
  int     mode      = 0;
  bit     checking  = 1'b0;
  int     errors    = 0;
  int     tests_ok  = 0;
  int     tests_bad = 0;
  int     passed [NUM_CH];

  iq_squelch_top #(
    .DELAY     (DELAY),
    .AVG_POWER (AVG_POWER)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (valid_in),
    .i_in      (i_in),
    .q_in      (q_in),
    .valid_out (valid_out),
    .i_out     (i_out),
    .q_out     (q_out),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr)
  );

  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic int approx_mag(input logic signed [SAMPLE_W-1:0] i,
                                    input logic signed [SAMPLE_W-1:0] q);
    int a;
    int b;
    a = (i < 0) ? -int'(i) : int'(i);
    b = (q < 0) ? -int'(q) : int'(q);
    if (a >= b) begin
      return a + (b >> 1);
    end
    return b + (a >> 1);
  endfunction

  // integer mean of the last WINDOW magnitudes
  function automatic int window_mean(input int ch);
    int s;
    s = 0;
    for (int k = 0; k < WINDOW; k++) begin
      s += hist[ch][k];
    end
    return s >> AVG_POWER;
  endfunction

  function automatic logic gate_is_open(input int ch);
    return (window_mean(ch) > int'(m_thresh)) || (m_cnt[ch] < int'(m_hang));
  endfunction

  function automatic logic [NUM_CH-1:0] model_status();
    logic [NUM_CH-1:0] s;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      s[ch] = gate_is_open(ch);
    end
    return s;
  endfunction

  task automatic model_reset();
    m_thresh = RST_THRESH;
    m_hang   = RST_HANG;
    m_en     = RST_ENABLE;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      m_cnt[ch]  = 2 ** HANG_W - 1;
      mag_s1[ch] = 0;
      mag_s2[ch] = 0;
      mv[ch]     = 1'b0;
      mi[ch]     = '0;
      mq[ch]     = '0;
      for (int k = 0; k < WINDOW; k++) begin
        hist[ch][k] = 0;
      end
      for (int k = 0; k < DELAY; k++) begin
        dq[ch][k] = '0;
      end
    end
  endtask

  // one clock edge with the output side first so every stage sees pre-edge values
  task automatic model_step();
    logic open;
    logic pass;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      open   = gate_is_open(ch);
      pass   = window_mean(ch) > int'(m_thresh);
      mv[ch] = dq[ch][DELAY-1][2*SAMPLE_W] && open && m_en[ch];
      mi[ch] = dq[ch][DELAY-1][2*SAMPLE_W-1:SAMPLE_W];
      mq[ch] = dq[ch][DELAY-1][SAMPLE_W-1:0];
      if (pass) begin
        m_cnt[ch] = 0;
      end else if (m_cnt[ch] < int'(m_hang)) begin
        m_cnt[ch] = m_cnt[ch] + 1;
      end
      for (int k = DELAY - 1; k > 0; k--) begin
        dq[ch][k] = dq[ch][k-1];
      end
      dq[ch][0] = {valid_in[ch], i_in[ch*SAMPLE_W +: SAMPLE_W], q_in[ch*SAMPLE_W +: SAMPLE_W]};
      for (int k = WINDOW - 1; k > 0; k--) begin
        hist[ch][k] = hist[ch][k-1];
      end
      hist[ch][0] = mag_s2[ch];
      mag_s2[ch]  = mag_s1[ch];
      mag_s1[ch]  = approx_mag(i_in[ch*SAMPLE_W +: SAMPLE_W], q_in[ch*SAMPLE_W +: SAMPLE_W]);
    end
    // settings change at the end of a valid write access
    if (psel && penable && pwrite) begin
      case (paddr)
        ADDR_THRESH: m_thresh = pwdata[MAG_W-1:0];
        ADDR_HANG:   m_hang   = pwdata[HANG_W-1:0];
        ADDR_ENABLE: m_en     = pwdata[NUM_CH-1:0];
        default: ;
      endcase
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      model_reset();
    end else begin
      model_step();
    end
  end

  //////////////////////////////////////////////////
  // stimulus, checks and bus tasks
  //////////////////////////////////////////////////

  // mode 1 low level, 2 full scale, 3 silence with valid, else idle
  always @(posedge clk) begin
    #1;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      case (mode)
        1: begin
          valid_in[ch]                  = 1'($random(seed));
          i_in[ch*SAMPLE_W +: SAMPLE_W] = SAMPLE_W'($random(seed) % 8);
          q_in[ch*SAMPLE_W +: SAMPLE_W] = SAMPLE_W'($random(seed) % 8);
        end
        2: begin
          valid_in[ch]                  = 1'($random(seed));
          i_in[ch*SAMPLE_W +: SAMPLE_W] = SAMPLE_W'($random(seed));
          q_in[ch*SAMPLE_W +: SAMPLE_W] = SAMPLE_W'($random(seed));
        end
        3: begin
          valid_in[ch]                  = 1'b1;
          i_in[ch*SAMPLE_W +: SAMPLE_W] = '0;
          q_in[ch*SAMPLE_W +: SAMPLE_W] = '0;
        end
        default: begin
          valid_in[ch]                  = 1'b0;
          i_in[ch*SAMPLE_W +: SAMPLE_W] = '0;
          q_in[ch*SAMPLE_W +: SAMPLE_W] = '0;
        end
      endcase
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0d ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (checking) begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        check_value($sformatf("ch%0d valid_out", ch), 32'(valid_out[ch]), 32'(mv[ch]));
        if (mv[ch]) begin
          check_value($sformatf("ch%0d i_out", ch),
                      32'(i_out[ch*SAMPLE_W +: SAMPLE_W]), 32'(mi[ch]));
          check_value($sformatf("ch%0d q_out", ch),
                      32'(q_out[ch*SAMPLE_W +: SAMPLE_W]), 32'(mq[ch]));
        end
        if (valid_out[ch]) begin
          passed[ch]++;
        end
      end
    end
  end

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                           output logic err);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #1;
    penable = 1'b1;
    #2;
    err = pslverr;
    check_value("pready in write access", 32'(pready), 32'd1);
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // open_bits is the model's gate state at the moment prdata is sampled
  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic err, output logic [NUM_CH-1:0] open_bits);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk);
    #1;
    penable = 1'b1;
    #2;
    data      = prdata;
    err       = pslverr;
    open_bits = model_status();
    check_value("pready in read access", 32'(pready), 32'd1);
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic set_mode(input int m);
    @(negedge clk);
    mode = m;
  endtask

  task automatic run_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    int                errs0;
    logic [31:0]       rd;
    logic              err;
    logic [NUM_CH-1:0] st;
    int                snap [NUM_CH];
    int                hang_v;
    int                thr_v;

    repeat (10) @(posedge clk);
    #1;
    rst_n    = 1'b1;
    checking = 1'b1;

    errs0 = errors;
    apb_read(ADDR_THRESH, rd, err, st);
    check_value("THRESH after reset", rd, 32'(RST_THRESH));
    apb_read(ADDR_HANG, rd, err, st);
    check_value("HANG after reset", rd, 32'(RST_HANG));
    apb_read(ADDR_ENABLE, rd, err, st);
    check_value("ENABLE after reset", rd, 32'(RST_ENABLE));
    apb_read(ADDR_STATUS, rd, err, st);
    check_value("STATUS after reset", rd, 32'd0);
    check_value("pslverr on mapped read", 32'(err), 32'd0);
    run_cycles(50);
    check_value("valid_out idle", 32'(valid_out), 32'd0);
    report_test("reset values", errs0);

    errs0 = errors;
    snap  = passed;
    set_mode(1);
    run_cycles(LOW_CYCLES);
    apb_read(ADDR_STATUS, rd, err, st);
    check_value("STATUS with low input", rd, 32'd0);
    for (int ch = 0; ch < NUM_CH; ch++) begin
      check_value($sformatf("ch%0d passes with low input", ch),
                  32'(passed[ch] - snap[ch]), 32'd0);
    end
    report_test("low level closed", errs0);

    errs0 = errors;
    snap  = passed;
    set_mode(2);
    run_cycles(HIGH_CYCLES);
    for (int ch = 0; ch < NUM_CH; ch++) begin
      check_value($sformatf("ch%0d passes with high input", ch),
                  32'(passed[ch] > snap[ch]), 32'd1);
    end
    report_test("high level open", errs0);

    // first round on reset settings and later rounds with random hang and threshold
    errs0 = errors;
    for (int r = 0; r < 3; r++) begin
      if (r > 0) begin
        @(negedge clk);
        hang_v = 16 + ({$random(seed)} % 40);
        thr_v  = 20 + ({$random(seed)} % 200);
        apb_write(ADDR_HANG, 32'(hang_v), err);
        check_value("pslverr on HANG write", 32'(err), 32'd0);
        apb_write(ADDR_THRESH, 32'(thr_v), err);
        check_value("pslverr on THRESH write", 32'(err), 32'd0);
      end
      set_mode(2);
      run_cycles(BURST_CYCLES);
      set_mode(3);
      run_cycles(QUIET_CYCLES);
      check_value("valid_out after hang", 32'(valid_out), 32'd0);
      apb_read(ADDR_STATUS, rd, err, st);
      check_value("STATUS after hang", rd, 32'd0);
    end
    report_test("burst and hang", errs0);

    errs0 = errors;
    apb_write(ADDR_ENABLE, 32'h0000_000b, err);
    set_mode(2);
    run_cycles(2);
    snap = passed;
    run_cycles(ENA_CYCLES);
    apb_read(ADDR_STATUS, rd, err, st);
    check_value("STATUS against model", rd, 32'(st));
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (ch == 2) begin
        check_value("disabled ch2 passes", 32'(passed[ch] - snap[ch]), 32'd0);
      end else begin
        check_value($sformatf("ch%0d passes while ch2 off", ch),
                    32'(passed[ch] > snap[ch]), 32'd1);
      end
    end
    apb_write(ADDR_ENABLE, 32'h0000_000f, err);
    report_test("channel enable", errs0);

    errs0 = errors;
    apb_read(4'h2, rd, err, st);
    check_value("pslverr on unmapped read", 32'(err), 32'd1);
    apb_write(4'h6, 32'hffff_ffff, err);
    check_value("pslverr on unmapped write", 32'(err), 32'd1);
    apb_write(ADDR_STATUS, 32'h0000_000f, err);
    check_value("pslverr on STATUS write", 32'(err), 32'd1);
    apb_read(ADDR_THRESH, rd, err, st);
    check_value("THRESH unchanged", rd, 32'(m_thresh));
    apb_read(ADDR_HANG, rd, err, st);
    check_value("HANG unchanged", rd, 32'(m_hang));
    apb_read(ADDR_ENABLE, rd, err, st);
    check_value("ENABLE unchanged", rd, 32'(m_en));
    report_test("bus errors", errs0);

    $display("tests passed %0d, failed %0d, check errors %0d", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the tests did not finish in the expected time");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: iq_squelch_top.f
iq_squelch_pkg.sv
iq_magnitude.sv
boxcar_avg.sv
sample_delay.sv
squelch_gate.sv
squelch_channel.sv
squelch_apb_regs.sv
iq_squelch_top.sv
tb_iq_squelch.sv

// File: run_sim.sh
#!/bin/sh
# build and run the iq squelch testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_iq_squelch \
  -f iq_squelch_top.f -o tb_iq_squelch

./obj_dir/tb_iq_squelch | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  echo "run_sim: simulation passed"
else
  echo "run_sim: simulation failed"
  exit 1
fi
